/* files.f */
hw/csr_pkg.sv
hw/csr_ctl_if.sv
hw/bit_counter.sv
hw/csr_seq_fsm.sv
hw/csr_unit.sv
hw/csr_storage.sv
hw/operand_shifter.sv
hw/csr_top.sv
sim/csr_asserts.sv
sim/csr_tb.sv

/* Makefile */
TOP := csr_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

/* sim/csr_tb.sv */
`timescale 1ns/1ps

module csr_tb;

   logic                i_clk;
   logic                i_rst;
   logic                i_cmd_valid;
   csr_pkg::csr_op_t    i_cmd_op;
   csr_pkg::csr_sel_t   i_cmd_sel;
   csr_pkg::trap_kind_t i_cmd_kind;
   logic [31:0]         i_cmd_wdata;
   logic                o_credit;
   logic                o_rsp_valid;
   logic [31:0]         o_rsp_rdata;
   logic                i_mtip;
   logic                o_irq_pending;

   logic                m_mie;                               // reference model state
   logic                m_mpie;
   logic                m_mtie;
   logic [31:0]         m_mcause;
   logic [31:0]         m_mscratch;
   logic [31:0]         m_mepc;

   csr_top dut0 (
      .i_clk, .i_rst, .i_cmd_valid, .i_cmd_op, .i_cmd_sel, .i_cmd_kind, .i_cmd_wdata,
      .o_credit, .o_rsp_valid, .o_rsp_rdata, .i_mtip, .o_irq_pending
   );

   initial begin
      i_clk = 1'b0;
      forever #20 i_clk = ~i_clk;                            // 40 ns period
   end

   // ----------------------------------------
   // reporting
   // ----------------------------------------
   task automatic report_failure(input string what);
      $display("%s", what);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
         $display("TB FAILED");
         $fatal(1);
      end
   endtask

   // ----------------------------------------
   // reference model
   // ----------------------------------------
   function automatic logic [31:0] model_value(input csr_pkg::csr_sel_t sel);
      case (sel)
         csr_pkg::SEL_MSTATUS:  return 32'h1800 | {28'd0, m_mie, 3'd0};  // mpp reads as ones
         csr_pkg::SEL_MIE:      return {24'd0, m_mtie, 7'd0};
         csr_pkg::SEL_MCAUSE:   return m_mcause;
         csr_pkg::SEL_MSCRATCH: return m_mscratch;
         default:               return m_mepc;
      endcase
   endfunction

   function automatic void update_model(input csr_pkg::csr_op_t op, input csr_pkg::csr_sel_t sel,
                                        input csr_pkg::trap_kind_t kind, input logic [31:0] wdata);
      logic [31:0] old;
      logic [31:0] nxt;
      old = model_value(sel);
      case (op)
         csr_pkg::OP_RW: nxt = wdata;
         csr_pkg::OP_RS: nxt = old | wdata;
         csr_pkg::OP_RC: nxt = old & ~wdata;
         default:        nxt = old;
      endcase
      if (op == csr_pkg::OP_TRAP) begin
         m_mepc   = wdata;                                   // operand is the trapping pc
         m_mpie   = m_mie;
         m_mie    = 1'b0;
         m_mcause = {(kind == csr_pkg::TRAP_IRQ), 27'd0, kind};
      end else if (op == csr_pkg::OP_MRET) begin
         m_mie = m_mpie;
      end else begin
         case (sel)
            csr_pkg::SEL_MSTATUS:  m_mie      = nxt[3];      // only mie is writable
            csr_pkg::SEL_MIE:      m_mtie     = nxt[7];
            csr_pkg::SEL_MCAUSE:   m_mcause   = nxt & 32'h8000_000f;
            csr_pkg::SEL_MSCRATCH: m_mscratch = nxt;
            default:               m_mepc     = nxt;
         endcase
      end
   endfunction

   // ----------------------------------------
   // random picks
   // ----------------------------------------
   function automatic csr_pkg::csr_op_t pick_csr_op(input int unsigned r);
      case (r % 3)
         0:       return csr_pkg::OP_RW;
         1:       return csr_pkg::OP_RS;
         default: return csr_pkg::OP_RC;
      endcase
   endfunction

   function automatic csr_pkg::csr_op_t pick_any_op(input int unsigned r);
      case (r % 5)
         0:       return csr_pkg::OP_RW;
         1:       return csr_pkg::OP_RS;
         2:       return csr_pkg::OP_RC;
         3:       return csr_pkg::OP_TRAP;
         default: return csr_pkg::OP_MRET;
      endcase
   endfunction

   function automatic csr_pkg::csr_sel_t pick_sel(input int unsigned r);
      case (r % 5)
         0:       return csr_pkg::SEL_MSTATUS;
         1:       return csr_pkg::SEL_MIE;
         2:       return csr_pkg::SEL_MCAUSE;
         3:       return csr_pkg::SEL_MSCRATCH;
         default: return csr_pkg::SEL_MEPC;
      endcase
   endfunction

   function automatic csr_pkg::trap_kind_t pick_kind(input int unsigned r);
      case (r % 6)
         0:       return csr_pkg::TRAP_JUMP;
         1:       return csr_pkg::TRAP_EBREAK;
         2:       return csr_pkg::TRAP_LOAD;
         3:       return csr_pkg::TRAP_STORE;
         4:       return csr_pkg::TRAP_IRQ;
         default: return csr_pkg::TRAP_ECALL;
      endcase
   endfunction

   // ----------------------------------------
   // command driver
   // ----------------------------------------
   task automatic send_cmd(input csr_pkg::csr_op_t op, input csr_pkg::csr_sel_t sel,
                           input csr_pkg::trap_kind_t kind, input logic [31:0] wdata,
                           output logic [31:0] rdata);
      int unsigned waited;
      @(negedge i_clk);
      assert (!o_rsp_valid) else report_failure("response held for more than one cycle");
      i_cmd_valid = 1'b1;                                    // one cycle under the credit
      i_cmd_op    = op;
      i_cmd_sel   = sel;
      i_cmd_kind  = kind;
      i_cmd_wdata = wdata;
      @(negedge i_clk);
      i_cmd_valid = 1'b0;
      waited      = 1;                                       // edges since acceptance
      while (!o_rsp_valid && waited < 100) begin
         assert (!o_credit) else report_failure("credit returned before the response");
         @(negedge i_clk);
         waited = waited + 1;
      end
      assert (o_rsp_valid) else report_failure("no response within 100 cycles of the command");
      check_value("response latency", 32'd34, waited);
      check_value("credit with response", 32'd1, {31'd0, o_credit});
      rdata = o_rsp_rdata;
   endtask

   task automatic run_cmd(input csr_pkg::csr_op_t op, input csr_pkg::csr_sel_t sel,
                          input csr_pkg::trap_kind_t kind, input logic [31:0] wdata);
      logic [31:0] exp_rsp;
      logic [31:0] got;
      // trap and mret answer with the saved pc
      if ((op == csr_pkg::OP_TRAP) || (op == csr_pkg::OP_MRET))
         exp_rsp = m_mepc;
      else
         exp_rsp = model_value(sel);
      send_cmd(op, sel, kind, wdata, got);
      check_value($sformatf("%s on %s", op.name(), sel.name()), exp_rsp, got);
      update_model(op, sel, kind, wdata);
   endtask

   task automatic check_irq();
      logic [31:0] r;
      r      = $urandom;
      i_mtip = r[0];                                         // new timer level mid cycle
      @(negedge i_clk);
      check_value("irq pending", {31'd0, i_mtip & m_mie & m_mtie}, {31'd0, o_irq_pending});
   endtask

   // ----------------------------------------
   // stimulus
   // ----------------------------------------
   initial begin
      void'($urandom(13922));
      i_rst       = 1'b1;
      i_cmd_valid = 1'b0;
      i_cmd_op    = csr_pkg::OP_RW;
      i_cmd_sel   = csr_pkg::SEL_MSTATUS;
      i_cmd_kind  = csr_pkg::TRAP_JUMP;
      i_cmd_wdata = 32'd0;
      i_mtip      = 1'b0;
      m_mie       = 1'b0;
      m_mpie      = 1'b0;
      m_mtie      = 1'b0;
      m_mcause    = 32'd0;
      m_mscratch  = 32'd0;
      m_mepc      = 32'd0;
      repeat (5) @(posedge i_clk);
      @(negedge i_clk);
      i_rst = 1'b0;
      check_value("credit after reset", 32'd0, {31'd0, o_credit});
      check_value("response after reset", 32'd0, {31'd0, o_rsp_valid});
      check_value("irq after reset", 32'd0, {31'd0, o_irq_pending});

      // read set with a zero operand is a plain read
      run_cmd(csr_pkg::OP_RS, csr_pkg::SEL_MSTATUS, csr_pkg::TRAP_JUMP, 32'd0);
      run_cmd(csr_pkg::OP_RS, csr_pkg::SEL_MIE, csr_pkg::TRAP_JUMP, 32'd0);
      run_cmd(csr_pkg::OP_RS, csr_pkg::SEL_MCAUSE, csr_pkg::TRAP_JUMP, 32'd0);
      run_cmd(csr_pkg::OP_RS, csr_pkg::SEL_MSCRATCH, csr_pkg::TRAP_JUMP, 32'd0);
      run_cmd(csr_pkg::OP_RS, csr_pkg::SEL_MEPC, csr_pkg::TRAP_JUMP, 32'd0);

      repeat (40) run_cmd(pick_csr_op($urandom), csr_pkg::SEL_MSCRATCH,
                          csr_pkg::TRAP_JUMP, $urandom);

      repeat (40) begin
         run_cmd(pick_csr_op($urandom), pick_sel($urandom % 2), csr_pkg::TRAP_JUMP, $urandom);
         check_irq();
      end

      // mixed traffic brings traps and mret in with mie set or clear
      repeat (150) begin
         run_cmd(pick_any_op($urandom), pick_sel($urandom), pick_kind($urandom), $urandom);
         check_irq();
      end

      $display("TB PASSED");
      $finish;
   end

endmodule

/* sim/csr_asserts.sv */
`timescale 1ns/1ps

module csr_asserts (
   input logic i_clk,
   input logic i_rst,
   input logic i_cmd_valid,
   input logic o_credit,
   input logic o_rsp_valid
);

   logic credit_q;                                           // requester holds its single credit

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         credit_q <= 1'b1;                                   // one credit handed out at reset
      end else if (i_cmd_valid) begin
         credit_q <= 1'b0;                                   // spent on the accepted command
      end else if (o_credit) begin
         credit_q <= 1'b1;                                   // comes back with the response
      end
   end

   // ----------------------------------------
   // credit protocol
   // ----------------------------------------
   a_cmd_credit: assert property (@(posedge i_clk) disable iff (i_rst)
      i_cmd_valid |-> credit_q) else $error("command sent without a credit");

   a_cmd_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
      i_cmd_valid |=> !i_cmd_valid) else $error("command valid held for two cycles");

   // a credit can only come back while the requester has none
   a_credit_rsp: assert property (@(posedge i_clk) disable iff (i_rst)
      o_credit |-> !credit_q) else $error("credit returned while none was outstanding");

   a_reset_quiet: assert property (@(posedge i_clk)
      i_rst |=> (!o_credit && !o_rsp_valid)) else $error("outputs active after reset");

endmodule

bind csr_seq_fsm csr_asserts u_asserts (
   .i_clk(i_clk),
   .i_rst(i_rst),
   .i_cmd_valid(i_cmd_valid),
   .o_credit(o_credit),
   .o_rsp_valid(o_rsp_valid)
);

/* hw/csr_top.sv */
`timescale 1ns/1ps

module csr_top (
   input  logic                     i_clk,
   input  logic                     i_rst,
   input  logic                     i_cmd_valid,
   input  csr_pkg::csr_op_t         i_cmd_op,
   input  csr_pkg::csr_sel_t        i_cmd_sel,
   input  csr_pkg::trap_kind_t      i_cmd_kind,
   input  logic [csr_pkg::XLEN-1:0] i_cmd_wdata,
   output logic                     o_credit,
   output logic                     o_rsp_valid,
   output logic [csr_pkg::XLEN-1:0] o_rsp_rdata,
   input  logic                     i_mtip,
   output logic                     o_irq_pending
);

   csr_ctl_if ctl ();                                        // shared serial control strobes

   csr_seq_fsm u_fsm (
      .i_clk, .i_rst, .i_cmd_valid, .i_cmd_op, .i_cmd_sel, .i_cmd_kind,
      .o_credit, .o_rsp_valid, .ctl(ctl.fsm)
   );

   bit_counter u_cnt (.i_clk, .i_rst, .ctl(ctl.counter));

   csr_unit u_unit (.i_clk, .i_rst, .i_mtip, .o_irq_pending, .ctl(ctl.unit));

   csr_storage u_stor (.i_clk, .i_rst, .ctl(ctl.storage));

   operand_shifter u_shift (
      .i_clk, .i_rst, .i_cmd_valid, .i_cmd_wdata, .o_rsp_rdata, .ctl(ctl.shifter)
   );

endmodule

/* hw/operand_shifter.sv */
`timescale 1ns/1ps

module operand_shifter (
   input  logic                     i_clk,
   input  logic                     i_rst,
   input  logic                     i_cmd_valid,
   input  logic [csr_pkg::XLEN-1:0] i_cmd_wdata,
   output logic [csr_pkg::XLEN-1:0] o_rsp_rdata,
   csr_ctl_if.shifter               ctl
);

   logic [csr_pkg::XLEN-1:0] wd_q;                           // operand, drained lsb first
   logic [csr_pkg::XLEN-1:0] rx_q;                           // old value, filled from the top

   // ----------------------------------------
   // operand out
   // ----------------------------------------
   assign ctl.d = wd_q[0];

   always_ff @(posedge i_clk) begin
      if (i_cmd_valid & ctl.load) begin
         wd_q <= i_cmd_wdata;                                // same edge as the fsm capture
      end else if (ctl.run) begin
         wd_q <= {1'b0, wd_q[csr_pkg::XLEN-1:1]};
      end
   end

   // ----------------------------------------
   // old value in
   // ----------------------------------------
   // after 32 shifts bit 0 of the read value has reached rx_q[0]
   always_ff @(posedge i_clk) begin
      if (ctl.run) begin
         rx_q <= {ctl.q, rx_q[csr_pkg::XLEN-1:1]};
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_rsp_rdata <= '0;
      end else if (ctl.finish) begin
         o_rsp_rdata <= rx_q;                                // stable while o_rsp_valid is high
      end
   end

endmodule

/* hw/csr_storage.sv */
`timescale 1ns/1ps

module csr_storage (
   input  logic       i_clk,
   input  logic       i_rst,
   csr_ctl_if.storage ctl
);

   logic [csr_pkg::XLEN-1:0] mscratch_q;
   logic [csr_pkg::XLEN-1:0] mepc_q;
   logic                     csr_op;
   logic                     trap_op;
   logic                     mret_op;
   logic                     wr_scratch;
   logic                     wr_mepc;
   logic                     scratch_in;
   logic                     mepc_in;

   // ----------------------------------------
   // ring control
   // ----------------------------------------
   assign csr_op     = csr_pkg::is_csr_op(ctl.op);
   assign trap_op    = (ctl.op == csr_pkg::OP_TRAP);
   assign mret_op    = (ctl.op == csr_pkg::OP_MRET);
   assign wr_scratch = csr_op & (ctl.sel == csr_pkg::SEL_MSCRATCH);
   assign wr_mepc    = csr_op & (ctl.sel == csr_pkg::SEL_MEPC);

   // an untouched ring feeds its own lsb back to the top
   assign scratch_in = wr_scratch ? ctl.csr_in : mscratch_q[0];
   assign mepc_in    = wr_mepc ? ctl.csr_in :
                       trap_op ? ctl.d :                     // trap stores the operand pc
                       mepc_q[0];

   // mepc also answers trap and mret so the response carries the saved pc
   assign ctl.stor = (wr_scratch & mscratch_q[0]) |
                     ((wr_mepc | trap_op | mret_op) & mepc_q[0]);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         mscratch_q <= '0;
         mepc_q     <= '0;
      end else if (ctl.run) begin
         mscratch_q <= {scratch_in, mscratch_q[csr_pkg::XLEN-1:1]};   // full turn in 32 cycles
         mepc_q     <= {mepc_in, mepc_q[csr_pkg::XLEN-1:1]};
      end
   end

endmodule

/* hw/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit (
   input  logic    i_clk,
   input  logic    i_rst,
   input  logic    i_mtip,
   output logic    o_irq_pending,
   csr_ctl_if.unit ctl
);

   logic       mstatus_mie;
   logic       mstatus_mpie;
   logic       mie_mtie;
   logic [3:0] mcause3_0;                                    // exception code, rotates on access
   logic       mcause31;                                     // interrupt flag
   logic       csr_op;
   logic       trap_end;
   logic       mret_end;
   logic       cnt0to3;
   logic       sel_mstatus;
   logic       sel_mie;
   logic       sel_mcause;
   logic       rd_mstatus;
   logic       rd_mie;
   logic       rd_mcause;

   // ----------------------------------------
   // command decode
   // ----------------------------------------
   assign csr_op      = csr_pkg::is_csr_op(ctl.op) & ctl.run;
   assign trap_end    = ctl.run & ctl.last & (ctl.op == csr_pkg::OP_TRAP);
   assign mret_end    = ctl.run & ctl.last & (ctl.op == csr_pkg::OP_MRET);
   assign cnt0to3     = (ctl.cnt[csr_pkg::CNT_W-1:2] == '0);
   assign sel_mstatus = csr_op & (ctl.sel == csr_pkg::SEL_MSTATUS);
   assign sel_mie     = csr_op & (ctl.sel == csr_pkg::SEL_MIE);
   assign sel_mcause  = csr_op & (ctl.sel == csr_pkg::SEL_MCAUSE);

   // ----------------------------------------
   // read bit
   // ----------------------------------------
   // mpp bits are constant ones, mie is the only live bit of mstatus
   assign rd_mstatus = sel_mstatus & ((mstatus_mie & (ctl.cnt == csr_pkg::MSTATUS_MIE_BIT)) |
                                      (ctl.cnt == csr_pkg::MSTATUS_MPP_LO) |
                                      (ctl.cnt == csr_pkg::MSTATUS_MPP_HI));
   assign rd_mie     = sel_mie & (ctl.cnt == csr_pkg::MIE_MTIE_BIT) & mie_mtie;
   assign rd_mcause  = sel_mcause & ((cnt0to3 & mcause3_0[0]) | (ctl.last & mcause31));

   // storage only drives its bit when one of its rings is addressed
   assign ctl.q = rd_mstatus | rd_mie | rd_mcause | ctl.stor;

   // new bit of the selected register, trap and mret leave it as read
   assign ctl.csr_in = (ctl.op == csr_pkg::OP_RW) ? ctl.d :
                       (ctl.op == csr_pkg::OP_RS) ? (ctl.q | ctl.d) :
                       (ctl.op == csr_pkg::OP_RC) ? (ctl.q & ~ctl.d) :
                       ctl.q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         mstatus_mie  <= 1'b0;
         mstatus_mpie <= 1'b0;
         mie_mtie     <= 1'b0;
         mcause3_0    <= 4'b0000;
         mcause31     <= 1'b0;
      end else begin
         if (sel_mie & (ctl.cnt == csr_pkg::MIE_MTIE_BIT))
            mie_mtie <= ctl.csr_in;                          // written as bit 7 passes

         // trap, mret and a csr write of bit 3 never overlap
         if (trap_end)
            mstatus_mie <= 1'b0;
         else if (mret_end)
            mstatus_mie <= mstatus_mpie;
         else if (sel_mstatus & (ctl.cnt == csr_pkg::MSTATUS_MIE_BIT))
            mstatus_mie <= ctl.csr_in;

         if (trap_end)
            mstatus_mpie <= mstatus_mie;                     // not reachable from software

         // a trap overwrites the whole cause field on its last bit
         if (trap_end) begin
            mcause3_0 <= ctl.kind;
            mcause31  <= (ctl.kind == csr_pkg::TRAP_IRQ);
         end else begin
            if (sel_mcause & cnt0to3)
               mcause3_0 <= {ctl.csr_in, mcause3_0[3:1]};   // four shifts restore the order
            if (sel_mcause & ctl.last)
               mcause31 <= ctl.csr_in;
         end
      end
   end

   // timer is the only interrupt source
   assign o_irq_pending = i_mtip & mstatus_mie & mie_mtie;

endmodule

/* hw/csr_seq_fsm.sv */
`timescale 1ns/1ps

module csr_seq_fsm (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_cmd_valid,
   input  csr_pkg::csr_op_t    i_cmd_op,
   input  csr_pkg::csr_sel_t   i_cmd_sel,
   input  csr_pkg::trap_kind_t i_cmd_kind,
   output logic                o_credit,
   output logic                o_rsp_valid,
   csr_ctl_if.fsm              ctl
);

   typedef enum logic [1:0] {
      S_IDLE = 2'd0,                                         // waiting for a command
      S_RUN  = 2'd1,                                         // 32 serial cycles
      S_DONE = 2'd2                                          // result word is complete
   } state_t;

   state_t state_q;
   state_t state_nxt;
   logic   accept;
   logic   rsp_q;

   // ----------------------------------------
   // decode of the current state
   // ----------------------------------------
   assign ctl.load   = (state_q == S_IDLE);                  // only idle can take a command
   assign ctl.run    = (state_q == S_RUN);
   assign ctl.finish = (state_q == S_DONE);                  // shifter copies the result here
   assign accept     = i_cmd_valid & ctl.load;               // a credit is always honoured

   always_comb begin
      state_nxt = state_q;
      case (state_q)
         S_IDLE:  if (accept) state_nxt = S_RUN;
         S_RUN:   if (ctl.last) state_nxt = S_DONE;          // bit 31 goes out this cycle
         S_DONE:  state_nxt = S_IDLE;
         default: state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q  <= S_IDLE;
         rsp_q    <= 1'b0;
         ctl.op   <= csr_pkg::OP_RW;
         ctl.sel  <= csr_pkg::SEL_MSTATUS;
         ctl.kind <= csr_pkg::TRAP_JUMP;
      end else begin
         state_q <= state_nxt;
         rsp_q   <= ctl.finish;                              // response follows the done cycle
         if (accept) begin
            ctl.op   <= i_cmd_op;                            // held for the whole pass
            ctl.sel  <= i_cmd_sel;
            ctl.kind <= i_cmd_kind;
         end
      end
   end

   // the credit comes back with the response, depth is one
   assign o_rsp_valid = rsp_q;
   assign o_credit    = rsp_q;

endmodule

/* hw/bit_counter.sv */
`timescale 1ns/1ps

module bit_counter (
   input  logic         i_clk,
   input  logic         i_rst,
   csr_ctl_if.counter   ctl
);

   logic [csr_pkg::CNT_W-1:0] cnt_nxt;

   // ----------------------------------------
   // bit index of the serial pass
   // ----------------------------------------
   // wraps from 31 to 0 on its own, the fsm drops run at the same edge
   assign cnt_nxt = ctl.cnt + {{(csr_pkg::CNT_W-1){1'b0}}, 1'b1};

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ctl.cnt <= '0;                                      // first pass starts at bit 0
      end else if (ctl.run) begin
         ctl.cnt <= cnt_nxt;                                 // one bit per clock, lsb first
      end else begin
         ctl.cnt <= '0;                                      // idle keeps it parked at zero
      end
   end

   // cnt is zero outside run, so last can only fire inside a pass
   assign ctl.last = (ctl.cnt == csr_pkg::CNT_LAST);

endmodule

/* hw/csr_ctl_if.sv */
`timescale 1ns/1ps

interface csr_ctl_if;

   logic                       run;            // serial pass in progress
   logic                       load;           // fsm is idle and can capture a command
   csr_pkg::csr_op_t           op;             // latched command op
   csr_pkg::csr_sel_t          sel;            // latched register select
   csr_pkg::trap_kind_t        kind;           // latched trap cause
   logic                       finish;         // one cycle after the last bit
   logic [csr_pkg::CNT_W-1:0]  cnt;            // index of the bit on the wires this cycle
   logic                       last;           // cnt is at bit 31
   logic                       csr_in;         // new value bit for the selected register
   logic                       stor;           // bit from the shift storage
   logic                       d;              // serial operand bit
   logic                       q;              // old value bit of the selected register

   modport fsm     (output run, load, op, sel, kind, finish, input last);
   modport counter (input run, output cnt, last);
   modport unit    (input run, op, sel, kind, cnt, last, d, stor, output csr_in, q);
   modport storage (input run, op, sel, csr_in, d, output stor);
   modport shifter (input run, load, finish, q, output d);

endinterface

/* hw/csr_pkg.sv */
package csr_pkg;

   // ----------------------------------------
   // widths
   // ----------------------------------------
   localparam int unsigned XLEN  = 32;                      // register width in bits
   localparam int unsigned CNT_W = 5;                       // enough to index all 32 bits

   // bit positions are held as counter values so they compare directly with cnt
   localparam logic [CNT_W-1:0] MSTATUS_MIE_BIT = 5'd3;     // global interrupt enable
   localparam logic [CNT_W-1:0] MSTATUS_MPP_LO  = 5'd11;    // mpp always reads as machine mode
   localparam logic [CNT_W-1:0] MSTATUS_MPP_HI  = 5'd12;
   localparam logic [CNT_W-1:0] MIE_MTIE_BIT    = 5'd7;     // timer interrupt enable
   localparam logic [CNT_W-1:0] CNT_LAST        = 5'd31;    // final bit of the serial pass

   // ----------------------------------------
   // command encodings
   // ----------------------------------------
   typedef enum logic [2:0] {
      SEL_MSTATUS  = 3'd0,
      SEL_MIE      = 3'd1,
      SEL_MCAUSE   = 3'd2,
      SEL_MSCRATCH = 3'd3,
      SEL_MEPC     = 3'd4
   } csr_sel_t;

   typedef enum logic [2:0] {
      OP_RW   = 3'd0,                                       // old value out, operand in
      OP_RS   = 3'd1,                                       // old value out, old | operand in
      OP_RC   = 3'd2,                                       // old value out, old & ~operand in
      OP_TRAP = 3'd3,
      OP_MRET = 3'd4
   } csr_op_t;

   // the trap kind is its own exception code so it can be stored in mcause as is
   typedef enum logic [3:0] {
      TRAP_JUMP   = 4'd0,
      TRAP_EBREAK = 4'd3,
      TRAP_LOAD   = 4'd4,
      TRAP_STORE  = 4'd6,
      TRAP_IRQ    = 4'd7,
      TRAP_ECALL  = 4'd11
   } trap_kind_t;

   // true for the three ops that read and rewrite a selected register
   function automatic logic is_csr_op(csr_op_t op);
      return (op == OP_RW) || (op == OP_RS) || (op == OP_RC);
   endfunction

endpackage
